/* logic/rv_core_defs.svh */
// RV32 only with 32 registers; the reset pc must be word aligned
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// data path and instruction word width
`define RV_XLEN 32

// number of architectural integer registers
`define RV_REG_COUNT 32

// bits of a register index
`define RV_REG_AW 5

// pc value right after reset
`define RV_RESET_PC 32'h8000_0000

// pc advance for each accepted instruction
`define RV_INST_STEP 32'd4

`endif

/* logic/rv_core_pkg.sv */
// types and encodings for the RV32 execute core; covers only the implemented subset
package rv_core_pkg;

    // R format fields, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // I format with the 12 bit signed immediate on top
    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // S format splits the immediate around rs2/rs1/funct3
    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } inst_s_t;

    // U format, upper 20 bits of the result
    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    // one instruction word, read through the view its opcode selects
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_u_t u;
    } inst_t;

    // operations handed to the execute unit
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLTU,
        OP_SRA,
        OP_AND,
        OP_LUI,
        OP_AUIPC,
        OP_STORE,
        OP_ECALL,
        OP_EBREAK,
        OP_ILLEGAL
    } op_e;

    // major opcodes
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 values for the alu group
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_SRA  = 3'b101;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 values for stores, low two bits give the size
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // funct7 picks add vs sub and the arithmetic shift
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // system instructions are matched on the whole word
    localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

endpackage

/* logic/decode_if.sv */
// decoder to execute bundle; fields other than valid are meaningful only while valid is high
`timescale 1ns/100ps
`include "rv_core_defs.svh"

interface decode_if;
    import rv_core_pkg::*;

    // copy of the instruction strobe
    logic                   valid;
    // selected operation
    op_e                    op;
    // immediate already sign extended or shifted for its format
    logic [`RV_XLEN-1:0]    imm;
    // destination register index
    logic [`RV_REG_AW-1:0]  rd;
    // byte, half or word for stores
    logic [1:0]             store_size;
    // second alu operand comes from rs2 rather than the immediate
    logic                   src_rs2;

    // decoder side drives everything
    modport dec (
        output valid, op, imm, rd, store_size, src_rs2
    );

    // execute side only reads
    modport exe (
        input valid, op, imm, rd, store_size, src_rs2
    );

endinterface

/* logic/inst_decode.sv */
// purely combinational decoder; unsupported or partially matching encodings map to OP_ILLEGAL
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module inst_decode (
    input  rv_core_pkg::inst_t inst,
    input  logic               inst_valid,
    decode_if.dec              dec
);
    import rv_core_pkg::*;

    // strobe passes straight through
    assign dec.valid = inst_valid;

    // rd sits at the same place in every format that writes back
    assign dec.rd = inst.r.rd;

    // size code is the low part of the store funct3
    assign dec.store_size = inst.s.funct3[1:0];

    // only register-register ops take rs2 as the second operand
    assign dec.src_rs2 = (inst.r.opcode == OPC_REG);

    // operation select
    always_comb begin
        dec.op = OP_ILLEGAL;
        case (inst.r.opcode)
            OPC_IMM: begin
                case (inst.i.funct3)
                    F3_ADD:  dec.op = OP_ADD;
                    F3_SLTU: dec.op = OP_SLTU;
                    F3_AND:  dec.op = OP_AND;
                    // srai needs the alt funct7 and a 5 bit shamt
                    F3_SRA: begin
                        if (inst.r.funct7 == F7_ALT) begin
                            dec.op = OP_SRA;
                        end
                    end
                    default: dec.op = OP_ILLEGAL;
                endcase
            end
            OPC_REG: begin
                // add and sub share funct3 and only funct7 tells them apart
                if (inst.r.funct3 == F3_ADD) begin
                    if (inst.r.funct7 == F7_BASE) begin
                        dec.op = OP_ADD;
                    end else if (inst.r.funct7 == F7_ALT) begin
                        dec.op = OP_SUB;
                    end
                end
            end
            OPC_LUI:   dec.op = OP_LUI;
            OPC_AUIPC: dec.op = OP_AUIPC;
            OPC_STORE: begin
                // sd and friends are not part of rv32
                if (inst.s.funct3 inside {F3_SB, F3_SH, F3_SW}) begin
                    dec.op = OP_STORE;
                end
            end
            OPC_SYSTEM: begin
                // every other bit must be zero except the ebreak marker
                if (inst == INST_ECALL) begin
                    dec.op = OP_ECALL;
                end else if (inst == INST_EBREAK) begin
                    dec.op = OP_EBREAK;
                end
            end
            default: dec.op = OP_ILLEGAL;
        endcase
    end

    // the opcode picks the immediate format
    always_comb begin
        case (inst.r.opcode)
            // S type glues its two immediate pieces back together
            OPC_STORE: dec.imm = {{(`RV_XLEN-12){inst.s.imm_11_5[6]}},
                                  inst.s.imm_11_5, inst.s.imm_4_0};
            // U type has its low 12 bits at zero
            OPC_LUI,
            OPC_AUIPC: dec.imm = {inst.u.imm_31_12, 12'b0};
            // I layout for everything else since R and system ignore it
            default:   dec.imm = {{(`RV_XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
        endcase
    end

    // an x or z on the word would quietly decode as illegal
    always_comb begin
        if (dec.valid) begin
            assert (!$isunknown(inst))
                else $error("instruction word unknown while valid");
        end
    end

endmodule

/* logic/reg_file.sv */
// 32 x 32 bit registers; reads are combinational and see pre-edge contents, x0 never written
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [4:0]            rs1,
    input  logic [4:0]            rs2,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data,
    input  logic                  wr_en,
    input  logic [4:0]            wr_addr,
    input  logic [`RV_XLEN-1:0]   wr_data
);

    // register storage, entry 0 only ever holds its reset value
    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // write side
    // all entries clear on reset, writes to x0 are dropped here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read side
    // plain array lookup, no bypass from the write port
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 stays zero over any sequence of writes
    a_x0_rs1_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rs1 == '0) |-> (rs1_data == '0)
    ) else $error("x0 read nonzero on rs1");

    a_x0_rs2_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rs2 == '0) |-> (rs2_data == '0)
    ) else $error("x0 read nonzero on rs2");

endmodule

/* logic/exec_unit.sv */
// one cycle execute stage; no back-pressure, halted sticks until reset, stores leave only as outputs
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module exec_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    decode_if.exe                  dec,
    input  logic [`RV_XLEN-1:0]    rs1_data,
    input  logic [`RV_XLEN-1:0]    rs2_data,
    output logic                   wr_en,
    output logic [`RV_REG_AW-1:0]  wr_addr,
    output logic [`RV_XLEN-1:0]    wr_data,
    output logic                   wb_valid,
    output logic [`RV_REG_AW-1:0]  wb_rd,
    output logic [`RV_XLEN-1:0]    wb_data,
    output logic                   store_valid,
    output logic [`RV_XLEN-1:0]    store_addr,
    output logic [`RV_XLEN-1:0]    store_data,
    output logic [1:0]             store_size,
    output logic                   ecall,
    output logic                   illegal,
    output logic                   halted
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] st_data;
    logic                accept;
    logic                is_wb;
    logic                is_store;

    // strobes are dropped once halted
    assign accept = dec.valid && !halted;

    // second operand, rs2 only for the R group
    assign op_b = dec.src_rs2 ? rs2_data : dec.imm;

    // alu
    always_comb begin
        case (dec.op)
            OP_ADD:   result = rs1_data + op_b;
            OP_SUB:   result = rs1_data - op_b;
            OP_SLTU:  result = {{(`RV_XLEN-1){1'b0}}, (rs1_data < op_b)};
            // shift amount is the low 5 immediate bits
            OP_SRA:   result = $signed(rs1_data) >>> op_b[4:0];
            OP_AND:   result = rs1_data & op_b;
            OP_LUI:   result = dec.imm;
            // pc of this instruction, not the next one
            OP_AUIPC: result = pc + dec.imm;
            default:  result = '0;
        endcase
    end

    // store data keeps only the bytes the size covers
    always_comb begin
        case (dec.store_size)
            2'b00:   st_data = {{(`RV_XLEN-8){1'b0}}, rs2_data[7:0]};
            2'b01:   st_data = {{(`RV_XLEN-16){1'b0}}, rs2_data[15:0]};
            default: st_data = rs2_data;
        endcase
    end

    // ops that produce a register result
    assign is_wb = accept &&
                   (dec.op inside {OP_ADD, OP_SUB, OP_SLTU, OP_SRA, OP_AND, OP_LUI, OP_AUIPC});
    assign is_store = accept && (dec.op == OP_STORE);

    // write port, lands at the same edge the outputs register
    // rd of x0 is treated as no writeback at all
    assign wr_en   = is_wb && (dec.rd != '0);
    assign wr_addr = dec.rd;
    assign wr_data = result;

    // control state and pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= `RV_RESET_PC;
            wb_valid    <= 1'b0;
            store_valid <= 1'b0;
            ecall       <= 1'b0;
            illegal     <= 1'b0;
            halted      <= 1'b0;
        end else begin
            wb_valid    <= wr_en;
            store_valid <= is_store;
            ecall       <= accept && (dec.op == OP_ECALL);
            illegal     <= accept && (dec.op == OP_ILLEGAL);
            if (accept) begin
                pc <= pc + `RV_INST_STEP;
                // ebreak itself still counts as accepted
                if (dec.op == OP_EBREAK) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    // payload registers, only qualified by the pulses above
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_rd      <= dec.rd;
            wb_data    <= result;
            store_addr <= rs1_data + dec.imm;
            store_data <= st_data;
            store_size <= dec.store_size;
        end
    end

    // one instruction cannot both write back and store
    a_wb_store_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wb_valid && store_valid)
    ) else $error("wb_valid and store_valid together");

    // after ebreak nothing fires and the pc freezes
    a_quiet_halted: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |-> !(wb_valid || store_valid || ecall || illegal)
    ) else $error("pulse while halted");

    a_pc_frozen: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |=> (halted && $stable(pc))
    ) else $error("pc moved or halt cleared without reset");

endmodule

/* logic/rv_core.sv */
// execute-only RV32 core; one strobe per instruction, results one cycle later, no fetch or loads
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid,
    input  logic [`RV_XLEN-1:0]    inst,
    output logic                   wb_valid,
    output logic [`RV_REG_AW-1:0]  wb_rd,
    output logic [`RV_XLEN-1:0]    wb_data,
    output logic                   store_valid,
    output logic [`RV_XLEN-1:0]    store_addr,
    output logic [`RV_XLEN-1:0]    store_data,
    output logic [1:0]             store_size,
    output logic                   ecall,
    output logic                   illegal,
    output logic                   halted
);
    import rv_core_pkg::*;

    inst_t                 inst_w;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic                  wr_en;
    logic [`RV_REG_AW-1:0] wr_addr;
    logic [`RV_XLEN-1:0]   wr_data;

    // raw word viewed through the format union
    assign inst_w = inst_t'(inst);

    // decoder to execute
    decode_if dec_bus ();

    // decode runs beside the register reads
    inst_decode u_inst_decode (
        .inst       (inst_w),
        .inst_valid (inst_valid),
        .dec        (dec_bus)
    );

    // rs fields sit at the same bits in R and S, so one view serves both
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (inst_w.r.rs1),
        .rs2      (inst_w.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // execute, writeback and output registers
    exec_unit u_exec_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec         (dec_bus),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .store_size  (store_size),
        .ecall       (ecall),
        .illegal     (illegal),
        .halted      (halted)
    );

endmodule

/* testbench/rv_ref_model.svh */
// reference model for rv_core; call ref_reset after every reset and ref_exec once per strobe
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// expected outputs for one strobe
typedef struct packed {
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic [1:0]  store_size;
    logic        ecall;
    logic        illegal;
    logic        halted;
} exp_t;

// rv32 major opcodes, straight from the isa tables
localparam logic [6:0]  M_OPC_IMM    = 7'b0010011;
localparam logic [6:0]  M_OPC_REG    = 7'b0110011;
localparam logic [6:0]  M_OPC_LUI    = 7'b0110111;
localparam logic [6:0]  M_OPC_AUIPC  = 7'b0010111;
localparam logic [6:0]  M_OPC_STORE  = 7'b0100011;
localparam logic [31:0] M_ECALL      = 32'h0000_0073;
localparam logic [31:0] M_EBREAK     = 32'h0010_0073;

// architectural state of the model
logic [31:0] m_regs [32];
logic [31:0] m_pc;
logic        m_halted;

function automatic void ref_reset();
    for (int i = 0; i < 32; i++) begin
        m_regs[i] = '0;
    end
    m_pc     = `RV_RESET_PC;
    m_halted = 1'b0;
endfunction

// runs one instruction on the model state and returns what the core should show
function automatic exp_t ref_exec(input logic [31:0] w);
    exp_t               e;
    logic [4:0]         rd;
    logic [2:0]         f3;
    logic [6:0]         f7;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        imm_i;
    logic [31:0]        imm_s;
    logic [31:0]        imm_u;
    logic [31:0]        res;
    logic signed [31:0] a_s;
    logic               has_res;
    logic               bad;
    e = '0;
    e.halted = m_halted;
    // a halted core ignores the strobe entirely
    if (m_halted) begin
        return e;
    end
    rd    = w[11:7];
    f3    = w[14:12];
    f7    = w[31:25];
    a     = m_regs[w[19:15]];
    b     = m_regs[w[24:20]];
    a_s   = a;
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_u = {w[31:12], 12'h000};
    res     = '0;
    has_res = 1'b0;
    bad     = 1'b0;
    case (w[6:0])
        M_OPC_IMM: begin
            has_res = 1'b1;
            if (f3 == 3'b000) begin
                res = a + imm_i;
            end else if (f3 == 3'b011) begin
                // unsigned compare against the sign extended immediate
                res = (a < imm_i) ? 32'd1 : 32'd0;
            end else if (f3 == 3'b111) begin
                res = a & imm_i;
            end else if (f3 == 3'b101 && f7 == 7'b0100000) begin
                res = a_s >>> w[24:20];
            end else begin
                has_res = 1'b0;
                bad     = 1'b1;
            end
        end
        M_OPC_REG: begin
            has_res = (f3 == 3'b000) && (f7 == 7'b0000000 || f7 == 7'b0100000);
            bad     = !has_res;
            res     = (f7 == 7'b0100000) ? a - b : a + b;
        end
        M_OPC_LUI: begin
            has_res = 1'b1;
            res     = imm_u;
        end
        M_OPC_AUIPC: begin
            has_res = 1'b1;
            res     = m_pc + imm_u;
        end
        M_OPC_STORE: begin
            if (f3 <= 3'b010) begin
                e.store_valid = 1'b1;
                e.store_addr  = a + imm_s;
                e.store_size  = f3[1:0];
                if (f3 == 3'b000) begin
                    e.store_data = {24'h0, b[7:0]};
                end else if (f3 == 3'b001) begin
                    e.store_data = {16'h0, b[15:0]};
                end else begin
                    e.store_data = b;
                end
            end else begin
                bad = 1'b1;
            end
        end
        default: begin
            if (w == M_ECALL) begin
                e.ecall = 1'b1;
            end else if (w == M_EBREAK) begin
                m_halted = 1'b1;
                e.halted = 1'b1;
            end else begin
                bad = 1'b1;
            end
        end
    endcase
    e.illegal = bad;
    // x0 results are dropped with no writeback pulse
    if (has_res && rd != 5'd0) begin
        e.wb_valid   = 1'b1;
        e.wb_rd      = rd;
        e.wb_data    = res;
        m_regs[rd]   = res;
    end
    m_pc = m_pc + 32'd4;
    return e;
endfunction

`endif

/* testbench/tb_rv_core.sv */
// self-checking testbench for rv_core; include path needs logic and testbench, one strobe per op
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module tb_rv_core;

    // instruction counts per test
    localparam int N_IMM     = 40;
    localparam int N_REG     = 30;
    localparam int N_UPPER   = 16;
    localparam int N_STORE   = 24;
    localparam int N_ILLEGAL = 12;
    localparam int N_HALTED  = 4;
    localparam int N_SYS     = 2 + N_ILLEGAL + 1 + N_HALTED + 1;
    localparam int RESET_CYCLES = 5;
    // two cycles per instruction, both resets, then some slack for draining
    localparam int TIMEOUT_CYCLES =
        (N_IMM + N_REG + N_UPPER + N_STORE + N_SYS) * 2 + 2 * RESET_CYCLES + 100;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic [1:0]  store_size;
    logic        ecall;
    logic        illegal;
    logic        halted;

    `include "rv_ref_model.svh"

    // expected results waiting for their output cycle
    exp_t  exp_q [$];
    exp_t  cur_exp;
    string test_name;
    int    test_checks;
    int    test_errs;
    int    total_checks;
    int    total_errs;
    int    tests_run;
    int    tests_bad;
    int    cycles;

    rv_core u_rv_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .store_size  (store_size),
        .ecall       (ecall),
        .illegal     (illegal),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, M_OPC_IMM};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, M_OPC_REG};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], M_OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [4:0] rnd_reg();
        return 5'($urandom);
    endfunction

    function automatic logic [4:0] rnd_nz();
        return 5'($urandom_range(31, 1));
    endfunction

    // random word forced into an encoding the core does not implement
    function automatic logic [31:0] rnd_illegal();
        logic [31:0] w;
        int          pick;
        w    = $urandom;
        pick = $urandom_range(5, 0);
        case (pick)
            // load
            0: w[6:0] = 7'b0000011;
            // branch
            1: w[6:0] = 7'b1100011;
            // jal
            2: w[6:0] = 7'b1101111;
            // slli
            3: begin
                w[6:0]   = M_OPC_IMM;
                w[14:12] = 3'b001;
            end
            // mul group
            4: begin
                w[6:0]   = M_OPC_REG;
                w[31:25] = 7'b0000001;
            end
            // sd
            default: begin
                w[6:0]   = M_OPC_STORE;
                w[14:12] = 3'b011;
            end
        endcase
        return w;
    endfunction

    task automatic check_value(input string field, input logic [31:0] e, input logic [31:0] a);
        test_checks++;
        if (e !== a) begin
            $display("ERR %s %s expected %h actual %h", test_name, field, e, a);
            test_errs++;
        end
    endtask

    // payload fields only mean something while their pulse is expected
    task automatic compare_outputs(input exp_t e);
        check_value("wb_valid", 32'(e.wb_valid), 32'(wb_valid));
        check_value("store_valid", 32'(e.store_valid), 32'(store_valid));
        check_value("ecall", 32'(e.ecall), 32'(ecall));
        check_value("illegal", 32'(e.illegal), 32'(illegal));
        check_value("halted", 32'(e.halted), 32'(halted));
        if (e.wb_valid) begin
            check_value("wb_rd", 32'(e.wb_rd), 32'(wb_rd));
            check_value("wb_data", e.wb_data, wb_data);
        end
        if (e.store_valid) begin
            check_value("store_addr", e.store_addr, store_addr);
            check_value("store_data", e.store_data, store_data);
            check_value("store_size", 32'(e.store_size), 32'(store_size));
        end
    endtask

    // strobe sampled at a rising edge, outputs checked at the following falling edge
    initial begin
        forever begin
            @(posedge clk);
            if (rst_n && inst_valid) begin
                @(negedge clk);
                cur_exp = exp_q.pop_front();
                compare_outputs(cur_exp);
            end
        end
    end

    task automatic issue(input logic [31:0] w);
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = w;
        exp_q.push_back(ref_exec(w));
    endtask

    task automatic go_idle();
        @(negedge clk);
        inst_valid = 1'b0;
        inst       = $urandom;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic finish_test();
        go_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        tests_run++;
        total_checks += test_checks;
        total_errs   += test_errs;
        if (test_errs != 0) begin
            tests_bad++;
        end
        $display("test %s: %0d checks, %0d mismatches, %s", test_name, test_checks,
                 test_errs, (test_errs == 0) ? "ok" : "FAIL");
    endtask

    // pulse and hold the reset, then bring the model back in step
    task automatic apply_reset();
        @(negedge clk);
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        ref_reset();
    endtask

    task automatic run_imm_test();
        logic [31:0] w;
        int          kind;
        start_test("imm_ops");
        for (int n = 0; n < N_IMM; n++) begin
            kind = $urandom_range(3, 0);
            case (kind)
                0: w = enc_i(3'b000, rnd_reg(), rnd_reg(), 12'($urandom));
                1: w = enc_i(3'b011, rnd_reg(), rnd_reg(), 12'($urandom));
                2: w = enc_i(3'b111, rnd_reg(), rnd_reg(), 12'($urandom));
                default: w = enc_i(3'b101, rnd_reg(), rnd_reg(), {7'b0100000, rnd_reg()});
            endcase
            issue(w);
        end
        finish_test();
    endtask

    // each op reads the rd of the one before, every fifth targets x0
    task automatic run_reg_test();
        logic [4:0] prev;
        logic [4:0] rd;
        logic [6:0] f7;
        start_test("reg_chain");
        prev = rnd_nz();
        for (int n = 0; n < N_REG; n++) begin
            rd = (n % 5 == 4) ? 5'd0 : rnd_nz();
            f7 = ($urandom_range(1, 0) == 1) ? 7'b0100000 : 7'b0000000;
            issue(enc_r(f7, rnd_reg(), prev, rd));
            prev = rd;
        end
        finish_test();
    endtask

    task automatic run_upper_test();
        logic [6:0] opc;
        start_test("upper_imm");
        for (int n = 0; n < N_UPPER; n++) begin
            opc = (n % 2 == 0) ? M_OPC_LUI : M_OPC_AUIPC;
            issue(enc_u(opc, rnd_nz(), 20'($urandom)));
        end
        finish_test();
    endtask

    task automatic run_store_test();
        logic [2:0] f3;
        start_test("stores");
        for (int n = 0; n < N_STORE; n++) begin
            f3 = 3'($urandom_range(2, 0));
            issue(enc_s(f3, rnd_reg(), rnd_reg(), 12'($urandom)));
        end
        finish_test();
    endtask

    task automatic run_system_test();
        start_test("system");
        issue(M_ECALL);
        issue(M_ECALL);
        for (int n = 0; n < N_ILLEGAL; n++) begin
            issue(rnd_illegal());
        end
        issue(M_EBREAK);
        // these must all be swallowed
        for (int n = 0; n < N_HALTED; n++) begin
            issue(enc_i(3'b000, rnd_nz(), rnd_reg(), 12'($urandom)));
        end
        go_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        check_value("halted_level", 32'd1, 32'(halted));
        apply_reset();
        check_value("halted_after_reset", 32'd0, 32'(halted));
        // auipc of zero exposes the pc
        issue(enc_u(M_OPC_AUIPC, 5'd7, 20'd0));
        finish_test();
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h7d3fa876));
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        total_checks = 0;
        total_errs   = 0;
        tests_run    = 0;
        tests_bad    = 0;
        ref_reset();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        run_imm_test();
        run_reg_test();
        run_upper_test();
        run_store_test();
        run_system_test();
        $display("summary: %0d tests run, %0d with errors, %0d checks, %0d mismatches",
                 tests_run, tests_bad, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+logic
+incdir+testbench
logic/rv_core_pkg.sv
logic/decode_if.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/rv_core.sv
testbench/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the simulation, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "result: FAIL"; \
		exit 1; \
	fi
	@if ! grep -q "all tests passed" $(LOG); then \
		echo "result: no pass line in $(LOG)"; \
		exit 1; \
	fi
	@echo "result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
